// ==== src/dleft_pkg.sv ====
`default_nettype none

package dleft_pkg;

	// ============================================================
	// table and fifo geometry
	// ============================================================
	localparam int TABLE_AW    = 8;            // table address bits
	localparam int TABLE_DEPTH = 256;          // table entries
	localparam int FIFO_DEPTH  = 16;           // key fifo slots
	localparam int FIFO_CW     = 5;            // occupancy counter 0..16
	localparam logic [31:0] AGE_LIMIT = 32'd10000; // stamp distance for replace

	typedef logic [TABLE_AW-1:0] addr_t;       // table index
	typedef logic [127:0]        flow_id_t;    // flow identifier

	// incoming key of 224 bits
	typedef struct packed {
		flow_id_t    flow_id;                  // [223:96]
		logic [31:0] init_count;               // [95:64]
		logic [31:0] stamp;                    // [63:32]
		logic [31:0] hash;                     // [31:0] with low bits as table address
	} key_t;

	// table entry of 192 bits and all zero when empty
	typedef struct packed {
		flow_id_t    flow_id;                  // stored id
		logic [31:0] count;                    // hit count
		logic [31:0] stamp;                    // last seen stamp
	} entry_t;

	// ============================================================
	// encodings
	// ============================================================
	typedef enum logic [1:0] {V_INSERT, V_HIT, V_REPLACE, V_FORWARD} verdict_e;
	typedef enum logic {L_IDLE, L_DECIDE} lookup_state_e;
	typedef enum logic [2:0] {
		B_IDLE, B_WRITE, B_READ, B_WAIT, B_CAPTURE, B_HOLD
	} bus_state_e;

endpackage

`default_nettype wire

// ==== src/table_port_if.sv ====
`default_nettype none
`timescale 1ns/10ps

// one port of the flow table
interface table_port_if import dleft_pkg::*; ();

	logic   rd;                                // read strobe
	logic   wr;                                // write strobe
	addr_t  addr;                              // entry index
	entry_t wdata;                             // write data
	entry_t rdata;                             // registered read data

	modport client (
		output rd, wr, addr, wdata,
		input  rdata
	);

	modport memory (
		input  rd, wr, addr, wdata,
		output rdata
	);

endinterface

`default_nettype wire

// ==== src/key_fifo.sv ====
`default_nettype none
`timescale 1ns/10ps

module key_fifo import dleft_pkg::*; (
	input  wire  Clk,                          // core clock
	input  wire  Reset_N,                      // async, active low
	input  key_t in_key,                       // key from source
	input  wire  in_key_wr,                    // key strobe
	input  wire  pop,                          // consume head
	output key_t head,                         // oldest key, show-ahead
	output logic empty,                        // no key stored
	output logic in_key_alf                    // 15 or more keys
);

	// ============================================================
	// storage and pointers
	// ============================================================
	key_t               mem [FIFO_DEPTH];      // key slots
	logic [FIFO_CW-2:0] wr_ptr;                // next slot to write
	logic [FIFO_CW-2:0] rd_ptr;                // head slot
	logic [FIFO_CW-1:0] count;                 // keys held
	logic               full;                  // all slots used
	logic               wr_en;                 // accepted write
	logic               rd_en;                 // accepted pop

	assign full       = (count == FIFO_CW'(FIFO_DEPTH));
	assign empty      = (count == '0);
	assign in_key_alf = (count >= FIFO_CW'(FIFO_DEPTH - 1));
	assign wr_en      = in_key_wr && !full;    // overflow dropped
	assign rd_en      = pop && !empty;
	assign head       = mem[rd_ptr];           // no read latency

	// key payload
	always_ff @(posedge Clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= in_key;             // store at tail
		end
	end

	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			wr_ptr <= '0;                      // empty fifo
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;       // wraps at 16
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;       // wraps at 16
			end
		end
	end

	// occupancy
	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			count <= '0;
		end else begin
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1; // push only
				2'b01:   count <= count - 1'b1; // pop only
				default: count <= count;        // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/flow_table_ram.sv ====
`default_nettype none
`timescale 1ns/10ps

module flow_table_ram import dleft_pkg::*; (
	input wire            Clk,                 // core clock
	input wire            Reset_N,             // clears valid bits
	table_port_if.memory  port_a,              // lookup side
	table_port_if.memory  port_b               // host side
);

	// ============================================================
	// entry array and valid bits
	// ============================================================
	entry_t                 mem [TABLE_DEPTH]; // table payload
	logic [TABLE_DEPTH-1:0] valid;             // written since reset

	// port a written last so it wins a collision
	always_ff @(posedge Clk) begin
		if (port_b.wr) begin
			mem[port_b.addr] <= port_b.wdata;
		end
		if (port_a.wr) begin
			mem[port_a.addr] <= port_a.wdata;
		end
	end

	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			valid <= '0;                       // whole table reads empty
		end else begin
			if (port_a.wr) begin
				valid[port_a.addr] <= 1'b1;
			end
			if (port_b.wr) begin
				valid[port_b.addr] <= 1'b1;
			end
		end
	end

	// ============================================================
	// registered reads return old data on a same-edge write
	// ============================================================
	always_ff @(posedge Clk) begin
		if (port_a.rd) begin
			port_a.rdata <= valid[port_a.addr] ? mem[port_a.addr] : '0; // mask unwritten
		end
	end

	always_ff @(posedge Clk) begin
		if (port_b.rd) begin
			port_b.rdata <= valid[port_b.addr] ? mem[port_b.addr] : '0; // mask unwritten
		end
	end

endmodule

`default_nettype wire

// ==== src/flow_lookup.sv ====
`default_nettype none
`timescale 1ns/10ps

module flow_lookup import dleft_pkg::*; (
	input  wire          Clk,                  // core clock
	input  wire          Reset_N,              // async, active low
	input  wire          empty,                // fifo has no key
	input  key_t         head,                 // fifo head key
	output logic         pop,                  // take head
	input  wire          out_alf,              // downstream almost full
	table_port_if.client tbl,                  // table port a
	output key_t         out_key,              // forwarded key
	output logic         out_key_wr            // forward strobe
);

	// ============================================================
	// state and held key
	// ============================================================
	lookup_state_e state;                      // engine state
	key_t          key_q;                      // key under decision
	entry_t        cur;                        // entry read for key_q
	entry_t        new_entry;                  // entry to write back
	verdict_e      verdict;                    // outcome for key_q
	logic [31:0]   age;                        // key stamp minus entry stamp

	assign cur = tbl.rdata;
	assign age = key_q.stamp - cur.stamp;      // modulo 2^32

	// one key at a time and no pop while downstream is full
	assign pop = (state == L_IDLE) && !empty && !out_alf;

	// ============================================================
	// verdict priority empty > id match > aged > forward
	// ============================================================
	always_comb begin
		if (cur == '0) begin
			verdict = V_INSERT;                // free slot
		end else if (cur.flow_id == key_q.flow_id) begin
			verdict = V_HIT;                   // same flow
		end else if (age > AGE_LIMIT) begin
			verdict = V_REPLACE;               // stale owner
		end else begin
			verdict = V_FORWARD;               // slot busy and fresh
		end
	end

	// write-back entry
	always_comb begin
		case (verdict)
			V_HIT: begin
				new_entry.flow_id = cur.flow_id;
				new_entry.count   = cur.count + 32'd1; // one more packet
				new_entry.stamp   = key_q.stamp;       // refresh age
			end
			default: begin
				new_entry.flow_id = key_q.flow_id;     // insert or replace
				new_entry.count   = key_q.init_count;
				new_entry.stamp   = key_q.stamp;
			end
		endcase
	end

	// port a reads on pop and writes in decide
	always_comb begin
		tbl.rd    = pop;
		tbl.wr    = (state == L_DECIDE) && (verdict != V_FORWARD);
		tbl.wdata = new_entry;
		if (state == L_DECIDE) begin
			tbl.addr = key_q.hash[TABLE_AW-1:0]; // write back same slot
		end else begin
			tbl.addr = head.hash[TABLE_AW-1:0];  // read slot of head
		end
	end

	// ============================================================
	// control
	// ============================================================
	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			state      <= L_IDLE;
			out_key_wr <= 1'b0;
		end else begin
			out_key_wr <= 1'b0;                // single-cycle pulse
			case (state)
				L_IDLE: begin
					if (pop) begin
						state <= L_DECIDE;     // entry arrives this edge
					end
				end
				L_DECIDE: begin
					out_key_wr <= (verdict == V_FORWARD);
					state      <= L_IDLE;      // always two cycles per key
				end
				default: state <= L_IDLE;
			endcase
		end
	end

	// key payload
	always_ff @(posedge Clk) begin
		if (pop) begin
			key_q <= head;                     // capture popped key
		end
		if ((state == L_DECIDE) && (verdict == V_FORWARD)) begin
			out_key <= key_q;                  // pass on unchanged
		end
	end

endmodule

`default_nettype wire

// ==== src/mgmt_bus.sv ====
`default_nettype none
`timescale 1ns/10ps

module mgmt_bus import dleft_pkg::*; (
	input  wire          Clk,                  // core clock
	input  wire          Reset_N,              // async, active low
	input  wire          cs_n,                 // chip select, low active
	input  wire          rw,                   // 1 write, 0 read
	input  addr_t        addr,                 // entry index
	input  entry_t       wdata,                // host write data
	output entry_t       rdata,                // host read data
	output logic         ack_n,                // done, low active
	table_port_if.client tbl                   // table port b
);

	// ============================================================
	// bus state machine
	// ============================================================
	bus_state_e state;                         // bus cycle phase

	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			state  <= B_IDLE;
			ack_n  <= 1'b1;                    // idle high
			tbl.rd <= 1'b0;
			tbl.wr <= 1'b0;
		end else begin
			tbl.rd <= 1'b0;                    // strobes are pulses
			tbl.wr <= 1'b0;
			case (state)
				B_IDLE: begin
					if (!cs_n) begin
						state <= rw ? B_WRITE : B_READ;
					end
				end
				B_WRITE: begin
					tbl.wr <= 1'b1;            // table write issued
					ack_n  <= 1'b0;            // ack with the write
					state  <= B_HOLD;
				end
				B_READ: begin
					tbl.rd <= 1'b1;            // table read issued
					state  <= B_WAIT;
				end
				B_WAIT: begin
					state <= B_CAPTURE;        // ram registers data
				end
				B_CAPTURE: begin
					ack_n <= 1'b0;             // rdata valid with ack
					state <= B_HOLD;
				end
				B_HOLD: begin
					if (cs_n) begin
						ack_n <= 1'b1;         // host released
						state <= B_IDLE;
					end
				end
				default: state <= B_IDLE;
			endcase
		end
	end

	// ============================================================
	// address, data and read capture
	// ============================================================
	always_ff @(posedge Clk) begin
		if ((state == B_WRITE) || (state == B_READ)) begin
			tbl.addr <= addr;                  // latch host address
		end
		if (state == B_WRITE) begin
			tbl.wdata <= wdata;                // latch host data
		end
		if (state == B_CAPTURE) begin
			rdata <= tbl.rdata;                // hold for host
		end
	end

endmodule

`default_nettype wire

// ==== src/dleft_flow_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module dleft_flow_top import dleft_pkg::*; (
	input  wire    Clk,                        // core clock
	input  wire    Reset_N,                    // async, active low
	input  key_t   in_key,                     // incoming key
	input  wire    in_key_wr,                  // key strobe
	output logic   in_key_alf,                 // input almost full
	output key_t   out_key,                    // forwarded key
	output logic   out_key_wr,                 // forward strobe
	input  wire    out_alf,                    // downstream almost full
	input  wire    cs_n,                       // local bus select
	input  wire    rw,                         // 1 write, 0 read
	input  addr_t  addr,                       // table index
	input  entry_t wdata,                      // host write data
	output entry_t rdata,                      // host read data
	output logic   ack_n                       // local bus ack
);

	// ============================================================
	// internal links
	// ============================================================
	logic empty;                               // fifo empty
	logic pop;                                 // fifo pop
	key_t head;                                // fifo head

	table_port_if tbl_a ();                    // lookup port
	table_port_if tbl_b ();                    // host port

	key_fifo fifo_i (
		.Clk        (Clk),
		.Reset_N    (Reset_N),
		.in_key     (in_key),
		.in_key_wr  (in_key_wr),
		.pop        (pop),
		.head       (head),
		.empty      (empty),
		.in_key_alf (in_key_alf)
	);

	flow_lookup lookup_i (
		.Clk        (Clk),
		.Reset_N    (Reset_N),
		.empty      (empty),
		.head       (head),
		.pop        (pop),
		.out_alf    (out_alf),
		.tbl        (tbl_a.client),
		.out_key    (out_key),
		.out_key_wr (out_key_wr)
	);

	flow_table_ram ram_i (
		.Clk        (Clk),
		.Reset_N    (Reset_N),
		.port_a     (tbl_a.memory),
		.port_b     (tbl_b.memory)
	);

	mgmt_bus bus_i (
		.Clk        (Clk),
		.Reset_N    (Reset_N),
		.cs_n       (cs_n),
		.rw         (rw),
		.addr       (addr),
		.wdata      (wdata),
		.rdata      (rdata),
		.ack_n      (ack_n),
		.tbl        (tbl_b.client)
	);

endmodule

`default_nettype wire

// ==== tb/dleft_flow_assert.sv ====
`default_nettype none
`timescale 1ns/10ps

module dleft_flow_assert (
	input wire Clk,                            // core clock
	input wire Reset_N,                        // async, active low
	input wire pop,                            // fifo pop
	input wire empty,                          // fifo empty
	input wire fwd,                            // out_key_wr
	input wire tbl_wr,                         // table port write
	input wire cs_n,                           // bus select
	input wire ack_n                           // bus ack
);

	int errs = 0;                              // failed assertions

	a_pop_empty: assert property (@(posedge Clk) disable iff (!Reset_N) !(pop && empty))
		else begin
			$error("fifo popped while empty");
			errs++;
		end

	a_fwd_wr: assert property (@(posedge Clk) disable iff (!Reset_N) !(fwd && tbl_wr))
		else begin
			$error("forward strobe and table write together");
			errs++;
		end

	// ack only answers a selected cycle
	a_ack_fall: assert property (@(posedge Clk) disable iff (!Reset_N)
			$fell(ack_n) |-> $past(!cs_n))
		else begin
			$error("ack_n fell without chip select");
			errs++;
		end

	a_ack_hold: assert property (@(posedge Clk) disable iff (!Reset_N)
			(!ack_n && !cs_n) |=> !ack_n)
		else begin
			$error("ack_n rose before chip select release");
			errs++;
		end

endmodule

bind flow_lookup dleft_flow_assert lookup_chk (
	.Clk     (Clk),
	.Reset_N (Reset_N),
	.pop     (pop),
	.empty   (empty),
	.fwd     (out_key_wr),
	.tbl_wr  (tbl.wr),
	.cs_n    (1'b0),                           // no bus here
	.ack_n   (1'b0)
);

bind mgmt_bus dleft_flow_assert bus_chk (
	.Clk     (Clk),
	.Reset_N (Reset_N),
	.pop     (1'b0),                           // no fifo here
	.empty   (1'b0),
	.fwd     (1'b0),
	.tbl_wr  (1'b0),
	.cs_n    (cs_n),
	.ack_n   (ack_n)
);

`default_nettype wire

// ==== tb/dleft_flow_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module dleft_flow_tb import dleft_pkg::*; ();

	// ============================================================
	// stimulus table
	// ============================================================
	typedef enum {R_PUSH, R_READ, R_WRITE, R_HOLD} row_kind_e;

	typedef struct {
		row_kind_e kind;                       // what the row does
		key_t      key;                        // pushed key
		addr_t     addr;                       // bus address
		entry_t    data;                       // write data or expected read
		logic      level;                      // out_alf to drive
		logic      alf_exp;                    // in_key_alf before the change
	} row_t;

	logic   Clk = 1'b0;
	logic   Reset_N;
	key_t   in_key;
	logic   in_key_wr;
	logic   in_key_alf;
	key_t   out_key;
	logic   out_key_wr;
	logic   out_alf;
	logic   cs_n;
	logic   rw;
	addr_t  addr;
	entry_t wdata;
	entry_t rdata;
	logic   ack_n;

	row_t        rows [$];                     // applied in order
	key_t        exp_out [$];                  // keys the model forwards
	entry_t      model_mem [TABLE_DEPTH];      // reference table
	logic [31:0] rng = 32'h3db06954;           // xorshift state
	int          mismatches = 0;
	int          failures = 0;
	int          asrt_errs;
	logic        hold_on = 1'b0;               // out_alf held high
	logic        built = 1'b0;

	always #4 Clk = ~Clk;                      // 8 ns period

	dleft_flow_top dut_i (.*);

	// ============================================================
	// random ids and reference model
	// ============================================================
	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	function automatic flow_id_t rand_id();
		flow_id_t id;
		for (int w = 0; w < 4; w++) begin
			id[w*32 +: 32] = xorshift32();
		end
		return id;
	endfunction

	task automatic add_push(input flow_id_t id, input logic [31:0] cnt,
			input logic [31:0] stamp, input addr_t a);
		key_t        k;
		entry_t      e;
		logic [31:0] age;
		logic [31:0] noise;
		noise        = xorshift32();
		k.flow_id    = id;
		k.init_count = cnt;
		k.stamp      = stamp;
		k.hash       = {noise[31:TABLE_AW], a}; // upper hash bits are noise
		e            = model_mem[a];
		age          = stamp - e.stamp;        // wraps mod 2^32
		if (e == '0) begin
			model_mem[a] = {id, cnt, stamp};   // insert
		end else if (e.flow_id == id) begin
			model_mem[a] = {id, e.count + 32'd1, stamp};
		end else if (age > AGE_LIMIT) begin
			model_mem[a] = {id, cnt, stamp};   // replace stale owner
		end else begin
			exp_out.push_back(k);              // forward unchanged
		end
		rows.push_back('{R_PUSH, k, '0, '0, 1'b0, 1'b0});
	endtask

	task automatic add_bus(input logic write, input addr_t a, input entry_t e);
		if (write) begin
			model_mem[a] = e;
			rows.push_back('{R_WRITE, '0, a, e, 1'b0, 1'b0});
		end else begin
			rows.push_back('{R_READ, '0, a, model_mem[a], 1'b0, 1'b0});
		end
	endtask

	task automatic build_rows();
		flow_id_t id_a;
		flow_id_t id_b;
		flow_id_t id_c;
		flow_id_t id_d;
		foreach (model_mem[j]) begin
			model_mem[j] = '0;                 // every entry empty after reset
		end
		id_a = rand_id();
		id_b = rand_id();
		id_c = rand_id();
		id_d = rand_id();
		add_bus(1'b0, 8'h12, '0);                    // cleared by reset
		add_push(id_a, 32'd5, 32'd100, 8'h12);       // insert
		add_bus(1'b0, 8'h12, '0);
		add_push(id_a, 32'd99, 32'd200, 8'h12);      // hit
		add_bus(1'b0, 8'h12, '0);
		add_push(id_b, 32'd7, 32'd10200, 8'h12);     // age equal to limit so forward
		add_bus(1'b0, 8'h12, '0);
		add_push(id_c, 32'd3, 32'd10201, 8'h12);     // one past limit so replace
		add_bus(1'b0, 8'h12, '0);
		add_push(id_b, 32'd1, 32'd50, 8'h12);        // wrapped stamp replaces
		add_bus(1'b0, 8'h12, '0);
		add_bus(1'b1, 8'h33, {id_d, 32'd41, 32'd7000});
		add_bus(1'b0, 8'h33, '0);
		add_push(id_d, 32'd0, 32'd7100, 8'h33);      // hit on host-written count
		add_bus(1'b0, 8'h33, '0);
		rows.push_back('{R_HOLD, '0, '0, '0, 1'b1, 1'b0});
		for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
			add_push(rand_id(), i, 32'd500 + i, 8'h40 + addr_t'(xorshift32() & 32'd3));
		end
		rows.push_back('{R_HOLD, '0, '0, '0, 1'b0, 1'b1});
		for (int i = 0; i < 4; i++) begin
			add_bus(1'b0, addr_t'(8'h40 + i), '0);
		end
	endtask

	// ============================================================
	// compare tasks
	// ============================================================
	task automatic check_key(input string name, input key_t got, input key_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic check_entry(input string name, input entry_t got, input entry_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
		end
	endtask

	// ============================================================
	// drivers called at a falling edge
	// ============================================================
	task automatic push_key(input key_t k);
		in_key    = k;
		in_key_wr = 1'b1;
		@(negedge Clk);
		in_key_wr = 1'b0;
		repeat (3) @(negedge Clk);             // pop plus decide
	endtask

	task automatic bus_cycle(input logic write, input addr_t a, input entry_t d);
		int n;
		cs_n  = 1'b0;
		rw    = write;
		addr  = a;
		wdata = write ? d : '0;
		repeat (write ? 2 : 4) @(negedge Clk); // ack edge
		check_bit("ack_n", ack_n, 1'b0);
		for (n = 0; n < 16 && ack_n; n++) begin
			@(negedge Clk);
		end
		if (ack_n) begin
			failures++;
			$display("bus cycle to address %h at %0t never got an ack", a, $time);
		end else if (!write) begin
			check_entry("rdata", rdata, d);
		end
		cs_n = 1'b1;
		for (n = 0; n < 16 && !ack_n; n++) begin
			@(negedge Clk);
		end
		if (!ack_n) begin
			failures++;
			$display("ack_n stayed low after chip select release at %0t", $time);
		end
	endtask

	task automatic apply_row(input row_t r);
		case (r.kind)
			R_PUSH:  push_key(r.key);
			R_READ:  bus_cycle(1'b0, r.addr, r.data);
			R_WRITE: bus_cycle(1'b1, r.addr, r.data);
			default: begin
				check_bit("in_key_alf", in_key_alf, r.alf_exp);
				out_alf = r.level;
				hold_on = r.level;
				if (!r.level) begin
					repeat (2 * FIFO_DEPTH + 4) @(negedge Clk); // drain at 2 cycles a key
				end
			end
		endcase
	endtask

	// forwarded keys checked in model order
	always @(posedge Clk) begin
		if (Reset_N && out_key_wr) begin
			if (hold_on) begin
				failures++;
				$display("key forwarded at %0t while out_alf was held high", $time);
			end
			if (exp_out.size() == 0) begin
				failures++;
				$display("unexpected forwarded key at %0t", $time);
			end else begin
				check_key("out_key", out_key, exp_out.pop_front());
			end
		end
	end

	initial begin
		wait (built);
		repeat (rows.size() * 40 + 200) @(posedge Clk);
		$display("watchdog expired at %0t, run did not finish", $time);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		Reset_N   = 1'b0;
		in_key    = '0;
		in_key_wr = 1'b0;
		out_alf   = 1'b0;
		cs_n      = 1'b1;
		rw        = 1'b0;
		addr      = '0;
		wdata     = '0;
		build_rows();
		built = 1'b1;
		repeat (4) @(negedge Clk);
		Reset_N = 1'b1;
		@(negedge Clk);
		check_bit("out_key_wr", out_key_wr, 1'b0);
		check_bit("ack_n", ack_n, 1'b1);
		check_bit("in_key_alf", in_key_alf, 1'b0);
		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
		repeat (4) @(negedge Clk);
		if (exp_out.size() != 0) begin
			failures++;
			$display("%0d expected keys were never forwarded", exp_out.size());
		end
		asrt_errs = dut_i.lookup_i.lookup_chk.errs + dut_i.bus_i.bus_chk.errs;
		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, failures, asrt_errs);
		if (mismatches + failures + asrt_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dleft_flow.f ====
src/dleft_pkg.sv
src/table_port_if.sv
src/key_fifo.sv
src/flow_table_ram.sv
src/flow_lookup.sv
src/mgmt_bus.sv
src/dleft_flow_top.sv
tb/dleft_flow_assert.sv
tb/dleft_flow_tb.sv

// ==== Bender.yml ====
package:
  name: dleft_flow

sources:
  - src/dleft_pkg.sv
  - src/table_port_if.sv
  - src/key_fifo.sv
  - src/flow_table_ram.sv
  - src/flow_lookup.sv
  - src/mgmt_bus.sv
  - src/dleft_flow_top.sv
  - target: test
    files:
      - tb/dleft_flow_assert.sv
      - tb/dleft_flow_tb.sv
